/* logic/frameBuffer.sv */
`timescale 1ns/100ps

// 320x240 rgb565 store, one write port and one read port
module frameBuffer
    import scalerPkg::*;
#(
    parameter int memDepth = 76800     // 320 * 240 words
)
(
    input  logic   CLK25,
    input  logic   wrEn,        // single clock pulse from the writer
    input  fbAddrT wrAddr,
    input  pixelT  wrData,
    input  fbAddrT rdAddr,      // from the scan stage
    output pixelT  rdData       // valid one clock after rdAddr
);

    // block ram, contents undefined until written
    pixelT mem [memDepth];

    // write port
    always_ff @(posedge CLK25) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read, a same-clock write returns the old word
    always_ff @(posedge CLK25) begin
        rdData <= mem[rdAddr];
    end

    // writer only issues in-range addresses
    wrAddrInRange: assert property (@(posedge CLK25)
        wrEn |-> (int'(wrAddr) < memDepth));

endmodule

/* logic/pixelWriter.sv */
`timescale 1ns/100ps
`include "scaler_settings.svh"

// four-phase req/ack host port, one pixel per handshake
module pixelWriter
    import scalerPkg::*;
(
    input  logic      CLK25,
    input  logic      rst,
    input  writeReqT  hostReq,
    output writeRespT hostResp,
    output logic      wrEn,         // one clock, in COMMIT
    output fbAddrT    wrAddr,
    output pixelT     wrData
);

    writerStateT state;
    srcXT        xHeld;         // captured request
    srcYT        yHeld;
    pixelT       pixelHeld;
    logic        inRange;

    // handshake FSM
    // IDLE -> COMMIT -> HOLD (ack up) -> RELEASE (ack down) -> IDLE
    always_ff @(posedge CLK25) begin
        if (rst) begin
            state <= IDLE;
            hostResp <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (hostReq.req) begin
                        state <= COMMIT;
                    end
                end
                COMMIT: begin
                    hostResp.ack <= 1'b1;           // ram write lands this edge
                    hostResp.reject <= !inRange;
                    state <= HOLD;
                end
                HOLD: begin
                    if (!hostReq.req) begin
                        state <= RELEASE;   // host let go
                    end
                end
                RELEASE: begin
                    hostResp <= '0;     // ack and reject drop together
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // grab the payload on the first clock req is seen
    always_ff @(posedge CLK25) begin
        if ((state == IDLE) && hostReq.req) begin
            xHeld <= hostReq.x;
            yHeld <= hostReq.y;
            pixelHeld <= hostReq.pixel;
        end
    end

    assign inRange = (xHeld < srcXT'(`SRC_WIDTH)) && (yHeld < srcYT'(`SRC_HEIGHT));

    // ram write port
    assign wrEn = (state == COMMIT) && inRange;
    assign wrAddr = srcToAddr(xHeld, yHeld);
    assign wrData = pixelHeld;

    // ack only answers a request
    ackAfterReq: assert property (@(posedge CLK25) disable iff (rst)
        $rose(hostResp.ack) |-> $past(hostReq.req));

    // write pulse is one clock and is followed by ack
    wrEnSingle: assert property (@(posedge CLK25) disable iff (rst)
        wrEn |=> (!wrEn && hostResp.ack));

    // accepted means written, rejected means untouched
    wrEnPerAccept: assert property (@(posedge CLK25) disable iff (rst)
        $rose(hostResp.ack) |-> ($past(wrEn) == !hostResp.reject));

endmodule

/* logic/scalerPkg.sv */
`include "scaler_settings.svh"

package scalerPkg;

    typedef logic [15:0] pixelT;                            // rgb565, red in [15:11]
    typedef logic [$clog2(`FB_DEPTH)-1:0] fbAddrT;          // 17 bits, row*320 + col
    typedef logic [$clog2(`H_TOTAL)-1:0] hCountT;           // 0..799
    typedef logic [$clog2(`V_TOTAL)-1:0] vCountT;           // 0..524
    typedef logic [$clog2(`SRC_WIDTH)-1:0] srcXT;           // source column
    typedef logic [$clog2(`SRC_HEIGHT)-1:0] srcYT;          // source row

    // scan stage result, one clock behind the counters
    typedef struct packed {
        logic   active;     // inside 640x480
        logic   hsyncN;
        logic   vsyncN;
        fbAddrT rdAddr;     // zero outside the visible area
    } scanT;

    // display outputs, all fields aligned
    typedef struct packed {
        logic  hsyncN;
        logic  vsyncN;
        logic  blankN;
        pixelT pixel;
    } videoT;

    // host write request, payload stable while req is high
    typedef struct packed {
        logic  req;
        srcXT  x;
        srcYT  y;
        pixelT pixel;
    } writeReqT;

    typedef struct packed {
        logic ack;
        logic reject;       // only meaningful with ack high
    } writeRespT;

    typedef enum logic [1:0] {IDLE, COMMIT, HOLD, RELEASE} writerStateT;

    // row*320 + col, as row*256 + row*64 + col
    function automatic fbAddrT srcToAddr(input srcXT x, input srcYT y);
        return fbAddrT'({y, 8'd0}) + fbAddrT'({y, 6'd0}) + fbAddrT'(x);
    endfunction

endpackage

/* logic/scaler_settings.svh */
`ifndef SCALER_SETTINGS_SVH
`define SCALER_SETTINGS_SVH

// source image held in the frame buffer
`define SRC_WIDTH   320
`define SRC_HEIGHT  240
`define FB_DEPTH    (`SRC_WIDTH * `SRC_HEIGHT)   // 76800 words

// horizontal timing, pixel clocks
`define H_DISPLAY   640
`define H_FRONT     16
`define H_SYNC      96
`define H_BACK      48

// vertical timing, lines
`define V_DISPLAY   480
`define V_FRONT     10
`define V_SYNC      2
`define V_BACK      33

// full line and full frame
`define H_TOTAL     (`H_DISPLAY + `H_FRONT + `H_SYNC + `H_BACK)   // 800
`define V_TOTAL     (`V_DISPLAY + `V_FRONT + `V_SYNC + `V_BACK)   // 525

// 640x480 at 60 Hz needs a 25 MHz pixel clock,
// each source pixel covers a 2x2 block on screen

`endif

/* logic/upscaleDisplay.sv */
`timescale 1ns/100ps

// 320x240 frame buffer shown 2x upscaled on a 640x480 display
module upscaleDisplay
    import scalerPkg::*;
(
    input  logic      CLK25,        // pixel clock
    input  logic      rst,
    input  writeReqT  hostReq,      // host pixel writes
    output writeRespT hostResp,
    output videoT     video         // sync, blank and colour
);

    // writer to ram
    logic   wrEn;
    fbAddrT wrAddr;
    pixelT  wrData;

    // scan to ram and output stage
    scanT   scan;
    pixelT  rdData;

    pixelWriter i_pixelWriter (
        .CLK25    (CLK25),
        .rst      (rst),
        .hostReq  (hostReq),
        .hostResp (hostResp),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData)
    );

    frameBuffer i_frameBuffer (
        .CLK25  (CLK25),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdAddr (scan.rdAddr),  // read address only
        .rdData (rdData)
    );

    upscaleScan i_upscaleScan (
        .CLK25 (CLK25),
        .rst   (rst),
        .scan  (scan)
    );

    videoOutput i_videoOutput (
        .CLK25  (CLK25),
        .rst    (rst),
        .scan   (scan),
        .rdData (rdData),
        .video  (video)
    );

endmodule

/* logic/upscaleScan.sv */
`timescale 1ns/100ps
`include "scaler_settings.svh"

// raster timing for 640x480 and the 2x nearest-neighbour read address
module upscaleScan
    import scalerPkg::*;
(
    input  logic CLK25,     // 25 MHz pixel clock
    input  logic rst,
    output scanT scan       // registered, one clock after the counters
);

    // counter limits
    localparam hCountT hLast = hCountT'(`H_TOTAL - 1);        // 799
    localparam vCountT vLast = vCountT'(`V_TOTAL - 1);        // 524
    localparam hCountT hVisible = hCountT'(`H_DISPLAY);
    localparam vCountT vVisible = vCountT'(`V_DISPLAY);

    // sync windows, end value is the first column/row after the pulse
    localparam hCountT hSyncStart = hCountT'(`H_DISPLAY + `H_FRONT);            // 656
    localparam hCountT hSyncEnd = hCountT'(`H_DISPLAY + `H_FRONT + `H_SYNC);    // 752
    localparam vCountT vSyncStart = vCountT'(`V_DISPLAY + `V_FRONT);            // 490
    localparam vCountT vSyncEnd = vCountT'(`V_DISPLAY + `V_FRONT + `V_SYNC);    // 492

    hCountT hCount;         // display column incl. porches
    vCountT vCount;         // display line incl. porches
    logic   visible;
    logic   hSyncZone;
    logic   vSyncZone;
    srcXT   srcX;
    srcYT   srcY;
    fbAddrT addrNext;

    // free running counters, 800 clocks per line, 525 lines per frame
    always_ff @(posedge CLK25) begin
        if (rst) begin
            hCount <= '0;
            vCount <= '0;
        end else if (hCount == hLast) begin
            hCount <= '0;   // end of line
            if (vCount == vLast) begin
                vCount <= '0;   // end of frame
            end else begin
                vCount <= vCount + 1'b1;
            end
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    assign visible = (hCount < hVisible) && (vCount < vVisible);
    assign hSyncZone = (hCount >= hSyncStart) && (hCount < hSyncEnd);
    assign vSyncZone = (vCount >= vSyncStart) && (vCount < vSyncEnd);

    // halve both display coordinates
    assign srcX = hCount[9:1];      // 0..319 while visible
    assign srcY = vCount[8:1];      // row below 480, msb is zero

    // same pixel twice per line, same line twice per frame
    assign addrNext = srcToAddr(srcX, srcY);

    // register everything together so the fields stay aligned
    always_ff @(posedge CLK25) begin
        if (rst) begin
            scan.active <= 1'b0;
            scan.hsyncN <= 1'b1;    // syncs idle high
            scan.vsyncN <= 1'b1;
            scan.rdAddr <= '0;
        end else begin
            scan.active <= visible;
            scan.hsyncN <= !hSyncZone;      // active low pulse
            scan.vsyncN <= !vSyncZone;
            if (visible) begin
                scan.rdAddr <= addrNext;
            end else begin
                scan.rdAddr <= '0;  // parked outside the picture
            end
        end
    end

    // address mapping must never leave the 320x240 buffer
    activeAddrInRange: assert property (@(posedge CLK25) disable iff (rst)
        scan.active |-> (scan.rdAddr < fbAddrT'(`FB_DEPTH)));

    // the address walks forward by at most one word within a line
    activeAddrStep: assert property (@(posedge CLK25) disable iff (rst)
        scan.active && $past(scan.active) && !$past(rst)
            |-> (scan.rdAddr - $past(scan.rdAddr)) <= fbAddrT'(1));

endmodule

/* logic/videoOutput.sv */
`timescale 1ns/100ps

// aligns scan controls with ram data and blanks the colour
module videoOutput
    import scalerPkg::*;
(
    input  logic  CLK25,
    input  logic  rst,
    input  scanT  scan,         // one clock behind the counters
    input  pixelT rdData,       // two clocks behind the counters
    output videoT video         // three clocks behind with all fields aligned
);

    // scan controls delayed once to meet rdData
    logic activeD;
    logic hsyncND;
    logic vsyncND;

    always_ff @(posedge CLK25) begin
        if (rst) begin
            activeD <= 1'b0;
            hsyncND <= 1'b1;
            vsyncND <= 1'b1;
        end else begin
            activeD <= scan.active;
            hsyncND <= scan.hsyncN;
            vsyncND <= scan.vsyncN;
        end
    end

    // output register
    always_ff @(posedge CLK25) begin
        if (rst) begin
            video.hsyncN <= 1'b1;
            video.vsyncN <= 1'b1;
            video.blankN <= 1'b0;   // blanked out of reset
            video.pixel <= '0;
        end else begin
            video.hsyncN <= hsyncND;
            video.vsyncN <= vsyncND;
            video.blankN <= activeD;
            if (activeD) begin
                video.pixel <= rdData;
            end else begin
                video.pixel <= '0;  // black in porches and sync
            end
        end
    end

    // no colour outside the picture
    blankedPixelZero: assert property (@(posedge CLK25) disable iff (rst)
        !video.blankN |-> (video.pixel == '0));

endmodule

/* runSim.sh */
#!/bin/bash
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/100ps \
    -f upscaleDisplay.f \
    --top-module upscaleDisplayTb \
    -Mdir build/verilator
./build/verilator/VupscaleDisplayTb

/* sim/displayCases.txt */
# pass name x y pixel(hex) reject
# pass 1 is written before the first checked frame, pass 2 before the second
1 cornerTopLeft 0 0 f800 0
1 cornerBottomRight 319 239 07e0 0
1 cornerTopRight 319 0 001f 0
1 cornerBottomLeft 0 239 ffff 0
1 middle 160 120 a5a5 0
1 middleRight 161 120 5a5a 0
1 middleLeft 159 120 1234 0
1 middleAbove 160 119 4321 0
1 middleBelow 160 121 0f0f 0
1 diagonal 100 50 7bef 0
1 blackPixel 10 10 0000 0
1 wrapTarget 0 11 3c3c 0
1 xOutOfRange 320 10 dead 1
1 yOutOfRange 10 240 beef 1
1 bothOutOfRange 511 255 ffff 1
1 repeatFirst 20 30 1111 0
1 repeatLast 20 30 2222 0
2 overwriteMiddle 160 120 0841 0
2 overwriteCorner 0 0 001f 0
2 overwriteDiagonal 100 50 ffe0 0
2 rejectBelowMiddle 160 240 ffff 1
2 rejectRightOfMiddle 400 120 ffff 1
2 overwriteFarCorner 319 239 8410 0

/* sim/upscaleDisplayTb.sv */
`timescale 1ns/100ps
`include "scaler_settings.svh"

// testbench for the 2x upscaling display
// writes and expected pixels come from a case file
module upscaleDisplayTb
    import scalerPkg::*;
();

    localparam int fbDepth = `FB_DEPTH;
    localparam int frameClocks = 420000;   // 800 x 525

    logic      CLK25 = 1'b0;
    logic      rst;
    writeReqT  hostReq;
    writeRespT hostResp;
    videoT     video;

    // cases from the file
    int    casePass [$];    // 1 before first frame or 2 for the overwrite group
    string caseName [$];
    int    caseX [$];
    int    caseY [$];
    pixelT casePixel [$];
    bit    caseReject [$];

    // last accepted write per source word
    pixelT model [fbDepth];
    bit    written [fbDepth];
    int    lastCase [fbDepth];

    int cycleCount = 0;
    int timeoutLimit = 3 * frameClocks;
    bit checkArmed = 1'b0;      // compare colours only in watched frames
    int framesSeen = 0;
    int visLines = 0;           // lines with blankN high in this frame

    upscaleDisplay i_upscaleDisplay (
        .CLK25    (CLK25),
        .rst      (rst),
        .hostReq  (hostReq),
        .hostResp (hostResp),
        .video    (video)
    );

    always #5 CLK25 = ~CLK25;   // 10 ns

    task automatic abortRun(input string why);
        $display("tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic checkPixel(input string name, input pixelT expected, input pixelT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            abortRun("pixel mismatch");
        end
    endtask

    task automatic checkResp(input string name, input writeRespT expected,
                             input writeRespT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected ack %b reject %b actual ack %b reject %b",
                     name, expected.ack, expected.reject, actual.ack, actual.reject);
            abortRun("host response mismatch");
        end
    endtask

    task automatic checkCount(input string name, input hCountT expected, input hCountT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            abortRun("raster count mismatch");
        end
    endtask

    task automatic checkVideo(input string name, input videoT expected, input videoT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            abortRun("video output mismatch");
        end
    endtask

    // one case per line and # lines skipped
    task automatic readCases();
        int    fd;
        int    fields;
        int    pass;
        int    x;
        int    y;
        int    rej;
        string line;
        string name;
        logic [15:0] pix;
        fd = $fopen("sim/displayCases.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open sim/displayCases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%d %s %d %d %h %d", pass, name, x, y, pix, rej);
            if (fields == 6) begin
                casePass.push_back(pass);
                caseName.push_back(name);
                caseX.push_back(x);
                caseY.push_back(y);
                casePixel.push_back(pix);
                caseReject.push_back(rej != 0);
            end
        end
        $fclose(fd);
    endtask

    // full four-phase write followed by a random idle gap
    task automatic hostWrite(input int idx);
        int        waited;
        int        gap;
        int        addr;
        writeRespT expResp;
        @(negedge CLK25);
        hostReq.x = srcXT'(caseX[idx]);     // payload first
        hostReq.y = srcYT'(caseY[idx]);
        hostReq.pixel = casePixel[idx];
        @(negedge CLK25);
        hostReq.req = 1'b1;
        waited = 0;
        @(negedge CLK25);
        while (!hostResp.ack) begin
            if (waited == 16) begin
                abortRun({"no ack for case ", caseName[idx]});
            end
            waited++;
            @(negedge CLK25);
        end
        expResp.ack = 1'b1;
        expResp.reject = caseReject[idx];
        checkResp(caseName[idx], expResp, hostResp);
        if (!caseReject[idx]) begin     // accepted so the reference follows
            addr = caseY[idx] * `SRC_WIDTH + caseX[idx];
            model[addr] = casePixel[idx];
            written[addr] = 1'b1;
            lastCase[addr] = idx;
        end
        hostReq.req = 1'b0;
        waited = 0;
        while (hostResp.ack) begin
            if (waited == 16) begin
                abortRun({"ack never dropped for case ", caseName[idx]});
            end
            waited++;
            @(negedge CLK25);
        end
        gap = $urandom_range(7, 0);
        repeat (gap) @(negedge CLK25);
    endtask

    // arm colour checks from the next vsync fall until the picture ends
    task automatic watchFrame();
        int startFrame;
        startFrame = framesSeen;
        wait (framesSeen != startFrame);
        checkArmed = 1'b1;
        wait (visLines == `V_DISPLAY);
        checkArmed = 1'b0;
    endtask

    // monitor for raster geometry, blanking and handshake order
    logic hsyncPrev;
    logic vsyncPrev;
    logic ackPrev;
    logic reqPrev;          // req as the writer saw it last edge
    bit   lineStarted;
    bit   frameStarted;
    int   lineClocks;
    int   hLowClocks;
    int   lineBlank;
    int   frameLines;
    int   vLowLines;
    int   blankCount;      // blankN-high cycles since vsync fall

    always @(posedge CLK25) begin : rasterMonitor     // samples on the rising edge
        int col;
        int row;
        int addr;
        if (rst) begin
            hsyncPrev = 1'b1;
            vsyncPrev = 1'b1;
            ackPrev = 1'b0;
            reqPrev = 1'b0;
            lineStarted = 1'b0;
            frameStarted = 1'b0;
            lineClocks = 0;
            hLowClocks = 0;
            lineBlank = 0;
            frameLines = 0;
            vLowLines = 0;
            blankCount = 0;
        end else begin
            if (hostResp.ack && !ackPrev && !reqPrev) begin
                abortRun("ack rose while req was low");
            end
            if (!hostResp.ack && ackPrev && reqPrev) begin
                abortRun("ack dropped while req was still high");
            end
            ackPrev = hostResp.ack;
            reqPrev = hostReq.req;
            if (!video.blankN) begin
                checkPixel("blanking", '0, video.pixel);    // black outside picture
            end
            if (vsyncPrev && !video.vsyncN) begin   // frame boundary
                if (frameStarted) begin
                    checkCount("frame lines", hCountT'(`V_TOTAL), hCountT'(frameLines));
                    checkCount("vsync low lines", hCountT'(`V_SYNC), hCountT'(vLowLines));
                    checkCount("visible lines", hCountT'(`V_DISPLAY), hCountT'(visLines));
                end
                frameStarted = 1'b1;
                frameLines = 0;
                vLowLines = 0;
                visLines = 0;
                blankCount = 0;
                framesSeen++;
            end
            if (hsyncPrev && !video.hsyncN) begin   // line boundary
                if (lineStarted) begin
                    checkCount("line clocks", hCountT'(`H_TOTAL), hCountT'(lineClocks));
                    checkCount("hsync low clocks", hCountT'(`H_SYNC), hCountT'(hLowClocks));
                    if (lineBlank != 0) begin
                        checkCount("visible clocks", hCountT'(`H_DISPLAY), hCountT'(lineBlank));
                        visLines++;
                    end
                end
                lineStarted = 1'b1;
                frameLines++;
                if (!video.vsyncN) begin
                    vLowLines++;
                end
                lineClocks = 0;
                hLowClocks = 0;
                lineBlank = 0;
            end
            if (video.blankN) begin
                col = blankCount % `H_DISPLAY;
                row = blankCount / `H_DISPLAY;
                addr = (row / 2) * `SRC_WIDTH + col / 2;    // 2x2 block source
                if (checkArmed && addr < fbDepth && written[addr]) begin
                    checkPixel(caseName[lastCase[addr]], model[addr], video.pixel);
                end
                blankCount++;
                lineBlank++;
            end
            lineClocks++;
            if (!video.hsyncN) begin
                hLowClocks++;
            end
            hsyncPrev = video.hsyncN;
            vsyncPrev = video.vsyncN;
        end
    end

    always @(posedge CLK25) begin
        cycleCount++;
        if (cycleCount > timeoutLimit) begin
            abortRun("timeout, the run took longer than its cycle budget");
        end
    end

    initial begin
        videoT idleVideo;
        void'($urandom(32'h954c_aaf9));
        rst = 1'b1;
        hostReq = '0;
        readCases();
        timeoutLimit = 3 * frameClocks + 64 * caseName.size();
        idleVideo.hsyncN = 1'b1;
        idleVideo.vsyncN = 1'b1;
        idleVideo.blankN = 1'b0;
        idleVideo.pixel = '0;
        repeat (5) @(negedge CLK25);    // 5 rising edges under reset
        checkVideo("reset state", idleVideo, video);
        checkResp("reset state", '0, hostResp);
        rst = 1'b0;
        for (int i = 0; i < caseName.size(); i++) begin
            if (casePass[i] == 1) begin
                hostWrite(i);
            end
        end
        watchFrame();
        for (int i = 0; i < caseName.size(); i++) begin
            if (casePass[i] == 2) begin    // overwrite group in vertical blanking
                hostWrite(i);
            end
        end
        watchFrame();
        $display("all tests passed");
        $finish;
    end

endmodule

/* upscaleDisplay.f */
+incdir+logic
logic/scalerPkg.sv
logic/frameBuffer.sv
logic/pixelWriter.sv
logic/upscaleScan.sv
logic/videoOutput.sv
logic/upscaleDisplay.sv
sim/upscaleDisplayTb.sv
